//--- Bender.yml
package:
  name: ifetch_mem

sources:
  - files:
      - design/mem_pkg.sv
      - design/icache_pkg.sv
      - design/icache_line_ram.sv
      - design/block_fetch_ctrl.sv
      - design/icache_ctrl.sv
      - design/ifetch_mem_top.sv
  - target: test
    files:
      - verif/ifetch_mem_tb.sv

//--- compile.f
design/mem_pkg.sv
design/icache_pkg.sv
design/icache_line_ram.sv
design/block_fetch_ctrl.sv
design/icache_ctrl.sv
design/ifetch_mem_top.sv
verif/ifetch_mem_tb.sv

//--- design/block_fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module block_fetch_ctrl
    import mem_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,

    // cache side
    input  wire        fill_req_i,
    input  wire addr_t fill_addr_i,
    output logic       fill_busy_o,
    output logic       fill_done_o,
    output block_t     fill_block_o,

    // external memory port
    output addr_t      ext_addr_o,
    output logic       ext_rd_o,
    input  wire word_t ext_data_i,
    input  wire        ext_valid_i
);

    localparam int               CNT_W     = $clog2(WORDS_PER_BLOCK);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(WORDS_PER_BLOCK - 1);

    logic                             busy_q;
    logic                             rd_q;
    logic                             done_q;
    logic [CNT_W-1:0]                 word_cnt_q;
    logic [ADDR_W-BLOCK_OFFSET_W-1:0] line_q;
    block_t                           block_q;
    logic                             last_word;

    assign last_word = (word_cnt_q == LAST_WORD);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q     <= 1'b0;
            rd_q       <= 1'b0;
            done_q     <= 1'b0;
            word_cnt_q <= '0;
        end else begin
            rd_q   <= 1'b0;
            done_q <= 1'b0;
            if (!busy_q) begin
                if (fill_req_i) begin
                    busy_q     <= 1'b1;
                    rd_q       <= 1'b1;
                    word_cnt_q <= '0;
                end
            end else if (ext_valid_i) begin
                if (last_word) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    // one word outstanding, next read right after the answer
                    word_cnt_q <= word_cnt_q + 1'b1;
                    rd_q       <= 1'b1;
                end
            end
        end
    end

    // line address and assembled block
    always_ff @(posedge clk_i) begin
        if (!busy_q && fill_req_i) begin
            line_q <= fill_addr_i[ADDR_W-1:BLOCK_OFFSET_W];
        end
        if (busy_q && ext_valid_i) begin
            block_q[word_cnt_q*WORD_W +: WORD_W] <= ext_data_i;
        end
    end

    assign ext_addr_o   = {line_q, word_cnt_q, {BYTE_OFFSET_W{1'b0}}};
    assign ext_rd_o     = rd_q;
    assign fill_busy_o  = busy_q;
    assign fill_done_o  = done_q;
    assign fill_block_o = block_q;

endmodule

`default_nettype wire

//--- design/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  wire              clk_i,
    input  wire              rst_i,

    // fetch stage
    input  wire addr_t       addr_i,
    input  wire              stall_i,
    output word_t            instr_o,
    output logic             instr_valid_o,

    // line RAM
    output logic             ram_en_o,
    output logic             ram_we_o,
    output index_t           ram_index_o,
    output line_entry_t      ram_wdata_o,
    input  wire line_entry_t ram_rdata_i,

    // block fetch controller
    output logic             fill_req_o,
    output addr_t            fill_addr_o,
    input  wire              fill_busy_i,
    input  wire              fill_done_i,
    input  wire block_t      fill_block_i
);

    icache_state_t        state_q;
    icache_state_t        state_d;
    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] valid_d;

    index_t               look_index_q;
    index_t               look_index_d;
    tag_t                 miss_tag_q;
    tag_t                 miss_tag_d;
    index_t               miss_index_q;
    index_t               miss_index_d;
    addr_t                miss_addr_q;
    addr_t                miss_addr_d;

    tag_t                 cur_tag;
    index_t               cur_index;
    tag_t                 stored_tag;
    block_t               stored_block;
    logic                 hit;

    function automatic word_t select_word(input block_t blk, input word_sel_t sel);
        return blk[sel*WORD_W +: WORD_W];
    endfunction

    assign cur_tag      = addr_tag(addr_i);
    assign cur_index    = addr_index(addr_i);
    assign stored_tag   = ram_rdata_i[$bits(line_entry_t)-1 -: TAG_W];
    assign stored_block = ram_rdata_i[BLOCK_W-1:0];

    // the RAM was read with the index seen at acceptance
    assign hit = valid_q[look_index_q]
               && (look_index_q == cur_index)
               && (stored_tag == cur_tag);

    always_comb begin
        state_d      = state_q;
        valid_d      = valid_q;
        look_index_d = look_index_q;
        miss_tag_d   = miss_tag_q;
        miss_index_d = miss_index_q;
        miss_addr_d  = miss_addr_q;

        ram_en_o      = 1'b0;
        ram_we_o      = 1'b0;
        ram_index_o   = cur_index;
        ram_wdata_o   = {miss_tag_q, fill_block_i};
        fill_req_o    = 1'b0;
        fill_addr_o   = {addr_i[ADDR_W-1:BLOCK_OFFSET_W], {BLOCK_OFFSET_W{1'b0}}};
        instr_o       = '0;
        instr_valid_o = 1'b0;

        unique case (state_q)
            ST_IDLE: begin
                if (!stall_i) begin
                    ram_en_o     = 1'b1;
                    look_index_d = cur_index;
                    state_d      = ST_LOOKUP;
                end
            end

            ST_LOOKUP: begin
                if (!stall_i) begin
                    if (hit) begin
                        instr_o       = select_word(stored_block, addr_word_sel(addr_i));
                        instr_valid_o = 1'b1;
                        state_d       = ST_IDLE;
                    end else if (!fill_busy_i) begin
                        fill_req_o   = 1'b1;
                        miss_tag_d   = cur_tag;
                        miss_index_d = cur_index;
                        miss_addr_d  = addr_i;
                        state_d      = ST_REFILL;
                    end
                end
            end

            ST_REFILL: begin
                // runs to the end even under stall
                if (fill_done_i) begin
                    ram_en_o              = 1'b1;
                    ram_we_o              = 1'b1;
                    ram_index_o           = miss_index_q;
                    valid_d[miss_index_q] = 1'b1;
                    if (addr_i == miss_addr_q) begin
                        instr_o       = select_word(fill_block_i, addr_word_sel(miss_addr_q));
                        instr_valid_o = 1'b1;
                    end
                    state_d = ST_IDLE;
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            valid_q <= valid_d;
        end
    end

    // lookup and miss bookkeeping
    always_ff @(posedge clk_i) begin
        look_index_q <= look_index_d;
        miss_tag_q   <= miss_tag_d;
        miss_index_q <= miss_index_d;
        miss_addr_q  <= miss_addr_d;
    end

endmodule

`default_nettype wire

//--- design/icache_line_ram.sv
`timescale 1ns/100ps
`default_nettype none

module icache_line_ram
    import icache_pkg::*;
(
    input  wire              clk_i,
    input  wire              en_i,
    input  wire              we_i,
    input  wire index_t      index_i,
    input  wire line_entry_t wdata_i,
    output line_entry_t      rdata_o
);

    // tag and data of every line, no reset on the array
    line_entry_t mem [NUM_LINES];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[index_i] <= wdata_i;
            end else begin
                // read data shows up one cycle after the enable
                rdata_o <= mem[index_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // direct mapped, 16-byte lines
    localparam int NUM_LINES  = 128;
    localparam int INDEX_W    = $clog2(NUM_LINES);
    localparam int WORD_SEL_W = $clog2(mem_pkg::WORDS_PER_BLOCK);
    localparam int TAG_W      = mem_pkg::ADDR_W - INDEX_W - mem_pkg::BLOCK_OFFSET_W;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

    // tag on top, line data below
    typedef logic [TAG_W+mem_pkg::BLOCK_W-1:0] line_entry_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } icache_state_t;

    function automatic tag_t addr_tag(input mem_pkg::addr_t a);
        return a[mem_pkg::ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input mem_pkg::addr_t a);
        return a[mem_pkg::BLOCK_OFFSET_W +: INDEX_W];
    endfunction

    function automatic word_sel_t addr_word_sel(input mem_pkg::addr_t a);
        return a[mem_pkg::BYTE_OFFSET_W +: WORD_SEL_W];
    endfunction

endpackage

`default_nettype wire

//--- design/ifetch_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module ifetch_mem_top
    import mem_pkg::*;
    import icache_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,

    input  wire addr_t addr_i,
    input  wire        stall_i,
    output word_t      instr_o,
    output logic       instr_valid_o,

    output addr_t      ext_addr_o,
    output logic       ext_rd_o,
    input  wire word_t ext_data_i,
    input  wire        ext_valid_i
);

    wire              ram_en;
    wire              ram_we;
    wire index_t      ram_index;
    wire line_entry_t ram_wdata;
    wire line_entry_t ram_rdata;

    wire              fill_req;
    wire addr_t       fill_addr;
    wire              fill_busy;
    wire              fill_done;
    wire block_t      fill_block;

    icache_ctrl u_icache_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .addr_i        (addr_i),
        .stall_i       (stall_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .ram_en_o      (ram_en),
        .ram_we_o      (ram_we),
        .ram_index_o   (ram_index),
        .ram_wdata_o   (ram_wdata),
        .ram_rdata_i   (ram_rdata),
        .fill_req_o    (fill_req),
        .fill_addr_o   (fill_addr),
        .fill_busy_i   (fill_busy),
        .fill_done_i   (fill_done),
        .fill_block_i  (fill_block)
    );

    icache_line_ram u_line_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .index_i (ram_index),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    block_fetch_ctrl u_block_fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fill_req_i   (fill_req),
        .fill_addr_i  (fill_addr),
        .fill_busy_o  (fill_busy),
        .fill_done_o  (fill_done),
        .fill_block_o (fill_block),
        .ext_addr_o   (ext_addr_o),
        .ext_rd_o     (ext_rd_o),
        .ext_data_i   (ext_data_i),
        .ext_valid_i  (ext_valid_i)
    );

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;

    // byte offset inside a word and inside a block
    localparam int BYTE_OFFSET_W  = $clog2(WORD_W / 8);
    localparam int BLOCK_OFFSET_W = $clog2(BLOCK_W / 8);

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    // lowest address word sits in the low bits
    typedef logic [BLOCK_W-1:0] block_t;

endpackage

`default_nettype wire

//--- verif/ifetch_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ifetch_mem_tb
    import mem_pkg::*;
    import icache_pkg::*;
;

    localparam int          CLK_PERIOD      = 8;
    localparam int          RESET_CYCLES    = 10;
    localparam int          NUM_TESTS       = 6;
    localparam int          WAIT_LIMIT      = 100;
    localparam int          LINE_BYTES      = WORDS_PER_BLOCK * 4;
    localparam int          CONFLICT_STRIDE = NUM_LINES * LINE_BYTES;
    localparam logic [31:0] SEED            = 32'h91c1fb6b;
    localparam word_t       MODEL_PATTERN   = 32'h5a5a_0000;

    localparam addr_t ADDR_A = 32'h0000_1234;
    localparam addr_t ADDR_B = ADDR_A + CONFLICT_STRIDE;
    localparam addr_t ADDR_C = 32'h0000_2468;
    localparam addr_t ADDR_D = 32'h0000_3a70;
    localparam addr_t ADDR_E = 32'h0000_4000;

    logic  clk_i       = 1'b0;
    logic  rst_i       = 1'b0;
    addr_t addr_i      = '0;
    logic  stall_i     = 1'b1;
    word_t ext_data_i  = '0;
    logic  ext_valid_i = 1'b0;

    word_t instr_o;
    logic  instr_valid_o;
    addr_t ext_addr_o;
    logic  ext_rd_o;

    int          cycle_cnt = 0;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          test_cnt  = 0;
    int          test_err  = 0;
    string       test_name = "";

    // memory model state
    logic        pending   = 1'b0;
    int unsigned wait_left = 0;
    addr_t       pend_addr = '0;
    int          rd_count  = 0;
    addr_t       rd_addrs[$];

    ifetch_mem_top DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .addr_i        (addr_i),
        .stall_i       (stall_i),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o),
        .ext_addr_o    (ext_addr_o),
        .ext_rd_o      (ext_rd_o),
        .ext_data_i    (ext_data_i),
        .ext_valid_i   (ext_valid_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic word_t model_word(input addr_t a);
        return a ^ MODEL_PATTERN;
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return a & ~addr_t'(LINE_BYTES - 1);
    endfunction

    // answers 0 to 3 cycles after each read
    initial begin
        int unsigned seed_val;
        seed_val = $urandom(SEED);
        forever begin
            @(posedge clk_i);
            ext_valid_i <= 1'b0;
            if (!rst_i) begin
                pending = 1'b0;
            end else begin
                if (pending) begin
                    wait_left = wait_left - 1;
                    if (wait_left == 0) begin
                        ext_valid_i <= 1'b1;
                        ext_data_i  <= model_word(pend_addr);
                        pending = 1'b0;
                    end
                end
                if (ext_rd_o) begin
                    pend_addr = ext_addr_o;
                    wait_left = $urandom % 4;
                    rd_count  = rd_count + 1;
                    rd_addrs.push_back(ext_addr_o);
                    if (wait_left == 0) begin
                        ext_valid_i <= 1'b1;
                        ext_data_i  <= model_word(ext_addr_o);
                    end else begin
                        pending = 1'b1;
                    end
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        assert (actual === expected) else begin
            err_cnt++;
            $display("mismatch %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        check_cnt++;
        assert (cond === 1'b1) else begin
            err_cnt++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err  = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == test_err) begin
            $display("test %0d %s: ok", test_cnt, test_name);
        end else begin
            $display("test %0d %s: %0d failed checks", test_cnt, test_name, err_cnt - test_err);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        rst_i   <= 1'b0;
        stall_i <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b1;
    endtask

    // present an address and hold it until instr_valid_o
    task automatic fetch_word(input addr_t a, output word_t data, output int latency,
                              output bit got);
        int start_edge;
        int n;
        got     = 1'b0;
        latency = 0;
        data    = '0;
        @(posedge clk_i);
        addr_i     <= a;
        stall_i    <= 1'b0;
        start_edge = cycle_cnt;
        for (n = 0; n < WAIT_LIMIT && !got; n++) begin
            @(posedge clk_i);
            if (instr_valid_o) begin
                got     = 1'b1;
                data    = instr_o;
                latency = cycle_cnt - start_edge;
                // park the cache in idle
                stall_i <= 1'b1;
            end
        end
        if (!got) begin
            stall_i <= 1'b1;
        end
    endtask

    task automatic check_fetch(input addr_t a, input int expect_reads, input bit is_hit);
        word_t data;
        int    latency;
        bit    got;
        int    rd_before;
        int    i;
        rd_before = rd_count;
        rd_addrs.delete();
        fetch_word(a, data, latency, got);
        check_true(got, $sformatf("no instr_valid_o for address 0x%0h", a));
        if (got) begin
            check_value($sformatf("instr_o @0x%0h", a), model_word(a), data);
            if (is_hit) begin
                check_value("hit latency", 2, latency);
            end
        end
        check_value("ext_rd_o count", expect_reads, rd_count - rd_before);
        for (i = 0; i < rd_addrs.size() && i < expect_reads; i++) begin
            check_value($sformatf("ext_addr_o read %0d", i), line_base(a) + 4 * i,
                        rd_addrs[i]);
        end
    endtask

    task automatic watch_quiet(input int cycles, input bit check_reads);
        repeat (cycles) begin
            @(posedge clk_i);
            check_true(!instr_valid_o, "instr_valid_o pulsed when no word was due");
            if (check_reads) begin
                check_true(!ext_rd_o, "ext_rd_o pulsed while the cache was held");
            end
        end
    endtask

    task automatic wait_ext_read();
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(posedge clk_i);
            seen = ext_rd_o;
        end
        check_true(seen, "refill never started an external read");
    endtask

    initial begin
        int rd_before;
        apply_reset();

        start_test("cold_miss");
        check_fetch(ADDR_A, WORDS_PER_BLOCK, 1'b0);
        end_test();

        start_test("hit");
        check_fetch(line_base(ADDR_A), 0, 1'b1);
        check_fetch(line_base(ADDR_A) + 8, 0, 1'b1);
        check_fetch(line_base(ADDR_A) + 12, 0, 1'b1);
        end_test();

        start_test("conflict_eviction");
        check_fetch(ADDR_B, WORDS_PER_BLOCK, 1'b0);
        check_fetch(ADDR_A, WORDS_PER_BLOCK, 1'b0);
        end_test();

        start_test("stall");
        @(posedge clk_i);
        addr_i  <= ADDR_C;
        stall_i <= 1'b1;
        watch_quiet(40, 1'b1);
        check_fetch(ADDR_C, WORDS_PER_BLOCK, 1'b0);
        end_test();

        start_test("abandoned_miss");
        rd_before = rd_count;
        @(posedge clk_i);
        addr_i  <= ADDR_D;
        stall_i <= 1'b0;
        wait_ext_read();
        // move away while the line is still coming in
        addr_i  <= ADDR_E;
        stall_i <= 1'b1;
        watch_quiet(40, 1'b0);
        check_value("ext_rd_o count", WORDS_PER_BLOCK, rd_count - rd_before);
        check_fetch(ADDR_D, 0, 1'b1);
        end_test();

        start_test("reset_clears_valid");
        apply_reset();
        check_fetch(ADDR_A, WORDS_PER_BLOCK, 1'b0);
        end_test();

        $display("tests %0d, checks %0d, failed checks %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // run limit from the test count
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", NUM_TESTS * 200);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
